//--- files.f
logic/loader_pkg.sv
logic/dma_stream_if.sv
logic/mmio_config.sv
logic/stream_reader.sv
logic/read_sequencer.sv
logic/stream_loader.sv
testbench/tb_clock.sv
testbench/stream_loader_tb.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= stream_loader_tb
FILE_LIST  ?= files.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/stream_loader_tb.sv
`default_nettype none

module stream_loader_tb;
    import loader_pkg::*;

    localparam int total_beats    = 14;
    localparam int timeout_cycles = 20 * total_beats + 2000;

    logic        clk;
    logic        rst_n;
    logic        mmio_wr_en;
    logic [15:0] mmio_wr_addr;
    logic [63:0] mmio_wr_data;
    logic [63:0] mmio_rd_data;
    logic        dma_rd_go;
    logic [63:0] dma_rd_addr;
    logic [13:0] dma_rd_size;
    logic        dma_rd_en;
    logic        dma_empty;
    beat_t       dma_rd_data;
    logic        dma_rd_done;
    logic        mem_rdy;
    logic [31:0] word_data;
    logic [1:0]  word_we;
    logic [127:0] block_data;
    logic        block_we;
    logic        compute_start;

    integer      seed = 32'h49a6;
    int          errors = 0;
    int          starts = 0;
    int          cycles = 0;

    // Per-stream expectations for the current run
    logic [63:0] run_addr [3];
    int          run_beats [3];
    logic        run_en [3];
    int          slice_cnt [3];
    logic [63:0] go_addr_q [$];
    int          go_size_q [$];

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    stream_loader u_stream_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_wr_en    (mmio_wr_en),
        .mmio_wr_addr  (mmio_wr_addr),
        .mmio_wr_data  (mmio_wr_data),
        .mmio_rd_data  (mmio_rd_data),
        .dma_rd_go     (dma_rd_go),
        .dma_rd_addr   (dma_rd_addr),
        .dma_rd_size   (dma_rd_size),
        .dma_rd_en     (dma_rd_en),
        .dma_empty     (dma_empty),
        .dma_rd_data   (dma_rd_data),
        .dma_rd_done   (dma_rd_done),
        .mem_rdy       (mem_rdy),
        .word_data     (word_data),
        .word_we       (word_we),
        .block_data    (block_data),
        .block_we      (block_we),
        .compute_start (compute_start)
    );

    // Beat content as the host memory holds it
    function automatic beat_t ref_beat(input logic [63:0] addr, input int idx);
        beat_t       b;
        logic [31:0] w;
        for (int j = 0; j < 16; j++) begin
            w = addr[63:32] ^ addr[31:0] ^ (32'(idx) << 8) ^ 32'(j);
            b[j*32 +: 32] = w * 32'h9e3779b1 + 32'(idx);
        end
        return b;
    endfunction

    function automatic int slices_per_beat(input int s);
        return (s == int'(triangles)) ? 4 : 16;
    endfunction

    function automatic int total_slices(input int s);
        return run_en[s] ? run_beats[s] * slices_per_beat(s) : 0;
    endfunction

    function automatic logic [127:0] expected_slice(input int s, input int n);
        beat_t b;
        int    per;
        per = slices_per_beat(s);
        b   = ref_beat(run_addr[s], n / per);
        if (s == int'(triangles)) begin
            return b[(n % per)*128 +: 128];
        end
        return 128'(b[(n % per)*32 +: 32]);
    endfunction

    task automatic expect_equal(input logic [127:0] got, input logic [127:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic record_slice(input int s, input logic [127:0] data, input string what);
        if (slice_cnt[s] >= total_slices(s)) begin
            $display("Unexpected %s write at time %0t", what, $time);
            errors++;
        end else begin
            expect_equal(data, expected_slice(s, slice_cnt[s]), what);
        end
        slice_cnt[s]++;
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        mmio_wr_addr <= addr;
        mmio_wr_data <= data;
        mmio_wr_en   <= 1'b1;
        @(posedge clk);
        mmio_wr_en   <= 1'b0;
    endtask

    task automatic program_stream(input int s, input logic [63:0] addr, input int beats,
                                  input logic en);
        run_addr[s]  = addr;
        run_beats[s] = beats;
        run_en[s]    = en;
        slice_cnt[s] = 0;
        if (en) begin
            go_addr_q.push_back(addr);
            go_size_q.push_back(beats);
        end
        mmio_write({en, 14'(beats), 1'b0}, addr);
    endtask

    task automatic run_loads(input int run_no);
        mmio_write(16'h0000, 64'd0);
        @(posedge clk);
        while (!compute_start) @(posedge clk);
        expect_equal(128'(mmio_rd_data), 128'(status_idle), "status before load done");
        @(posedge clk);
        expect_equal(128'(mmio_rd_data), 128'(status_loaded), "status after load");
        mmio_write(16'h0001, 64'd0);
        @(posedge clk);
        expect_equal(128'(mmio_rd_data), 128'(status_idle), "status after clear");
        expect_equal(128'(starts), 128'(run_no), "compute_start pulses");
        expect_equal(128'(go_addr_q.size()), 128'd0, "DMA go count");
    endtask

    // DMA receiver and memory ready model
    initial begin
        logic [63:0] d_addr;
        int          d_size;
        int          d_idx;
        int          done_wait;
        d_addr    = '0;
        d_size    = 0;
        d_idx     = 0;
        done_wait = 0;
        dma_empty   <= 1'b1;
        dma_rd_data <= '0;
        dma_rd_done <= 1'b0;
        mem_rdy     <= 1'b0;
        forever begin
            @(posedge clk);
            dma_rd_done <= 1'b0;
            if (dma_rd_go) begin
                if (go_addr_q.size() == 0) begin
                    $display("Unexpected DMA go at time %0t", $time);
                    errors++;
                end else begin
                    expect_equal(128'(dma_rd_addr), 128'(go_addr_q.pop_front()),
                                 "DMA go address");
                    expect_equal(128'(dma_rd_size), 128'(go_size_q.pop_front()),
                                 "DMA go size");
                end
                d_addr = dma_rd_addr;
                d_size = int'(dma_rd_size);
                d_idx  = 0;
                if (d_size == 0) done_wait = 2;
            end else if (dma_rd_en) begin
                if (d_idx >= d_size) begin
                    $display("DMA pop with no beat left at time %0t", $time);
                    errors++;
                end
                d_idx++;
                if (d_idx == d_size) done_wait = 2;
            end
            if (done_wait > 0) begin
                done_wait--;
                if (done_wait == 0) dma_rd_done <= 1'b1;
            end
            dma_rd_data <= ref_beat(d_addr, d_idx);
            dma_empty   <= (d_idx >= d_size) || (($random(seed) & 3) == 0);
            mem_rdy     <= ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (word_we[0]) begin
                record_slice(int'(ray_table), 128'(word_data), "ray-table word");
            end
            if (word_we[1]) begin
                expect_equal(128'(slice_cnt[0]), 128'(total_slices(0)),
                             "ray-table words before constants");
                record_slice(int'(constants), 128'(word_data), "constant word");
            end
            if (block_we) begin
                expect_equal(128'(mem_rdy), 128'd1, "block write with memory ready");
                expect_equal(128'(slice_cnt[1]), 128'(total_slices(1)),
                             "constant words before triangles");
                record_slice(int'(triangles), block_data, "triangle block");
            end
            if (compute_start) begin
                starts++;
                for (int s = 0; s < 3; s++) begin
                    expect_equal(128'(slice_cnt[s]), 128'(total_slices(s)),
                                 "slices before compute_start");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: loads not complete after %0d cycles", cycles);
            $display("Errors: %0d, compute_start pulses: %0d", errors, starts);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        mmio_wr_en   <= 1'b0;
        mmio_wr_addr <= '0;
        mmio_wr_data <= '0;
        for (int s = 0; s < 3; s++) begin
            run_addr[s]  = '0;
            run_beats[s] = 0;
            run_en[s]    = 1'b0;
            slice_cnt[s] = 0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        expect_equal(128'(mmio_rd_data), 128'(status_idle), "status after reset");
        repeat (4) begin
            @(posedge clk);
            expect_equal(128'({word_we, block_we, compute_start}), 128'd0,
                         "strobes after reset");
        end

        // All three streams
        program_stream(int'(ray_table), 64'h0000_0040_1000_0000, 3, 1'b1);
        program_stream(int'(constants), 64'h0000_0040_2000_0800, 2, 1'b1);
        program_stream(int'(triangles), 64'h0000_0040_3000_0000, 4, 1'b1);
        run_loads(1);

        // Constants skipped
        program_stream(int'(ray_table), 64'h0000_0123_4567_8000, 2, 1'b1);
        program_stream(int'(constants), 64'h0000_0123_0000_4000, 5, 1'b0);
        program_stream(int'(triangles), 64'h0000_0123_89ab_c000, 3, 1'b1);
        run_loads(2);

        repeat (20) @(posedge clk);
        expect_equal(128'(starts), 128'd2, "compute_start pulses at end");
        $display("Errors: %0d, compute_start pulses: %0d", errors, starts);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 4;
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release lines up with a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/stream_loader.sv
`default_nettype none

module stream_loader (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  mmio_wr_en,
    input  logic [loader_pkg::mmio_addr_w-1:0]    mmio_wr_addr,
    input  logic [loader_pkg::mmio_data_w-1:0]    mmio_wr_data,
    output wire  [loader_pkg::mmio_data_w-1:0]    mmio_rd_data,
    output wire                                   dma_rd_go,
    output wire  [loader_pkg::host_addr_w-1:0]    dma_rd_addr,
    output wire  [loader_pkg::beat_cnt_w-1:0]     dma_rd_size,
    output wire                                   dma_rd_en,
    input  logic                                  dma_empty,
    input  loader_pkg::beat_t                     dma_rd_data,
    input  logic                                  dma_rd_done,
    input  logic                                  mem_rdy,
    output wire  [31:0]                           word_data,
    output wire  [1:0]                            word_we,
    output wire  [127:0]                          block_data,
    output wire                                   block_we,
    output wire                                   compute_start
);
    import loader_pkg::*;

    logic                        run_start;
    logic                        load_done;
    logic [2:0][host_addr_w-1:0] desc_addr;
    logic [2:0][beat_cnt_w-1:0]  desc_beats;
    logic [2:0]                  desc_enable;
    word_t                       ray_word;
    word_t                       const_word;

    dma_stream_if ray_if ();
    dma_stream_if const_if ();
    dma_stream_if tri_if ();

    mmio_config u_mmio_config (
        .clk          (clk),
        .rst_n        (rst_n),
        .mmio_wr_en   (mmio_wr_en),
        .mmio_wr_addr (mmio_wr_addr),
        .mmio_wr_data (mmio_wr_data),
        .load_done    (load_done),
        .run_start    (run_start),
        .desc_addr    (desc_addr),
        .desc_beats   (desc_beats),
        .desc_enable  (desc_enable),
        .mmio_rd_data (mmio_rd_data)
    );

    read_sequencer u_read_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .run_start   (run_start),
        .desc_addr   (desc_addr),
        .desc_beats  (desc_beats),
        .desc_enable (desc_enable),
        .dma_empty   (dma_empty),
        .dma_rd_done (dma_rd_done),
        .ray_if      (ray_if),
        .const_if    (const_if),
        .tri_if      (tri_if),
        .dma_rd_go   (dma_rd_go),
        .dma_rd_en   (dma_rd_en),
        .dma_rd_addr (dma_rd_addr),
        .dma_rd_size (dma_rd_size),
        .load_done   (load_done)
    );

    // Word memories never stall
    stream_reader #(.slice_t(word_t)) u_ray_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (ray_if),
        .beats    (desc_beats[ray_table]),
        .beat     (dma_rd_data),
        .mem_rdy  (1'b1),
        .slice    (ray_word),
        .slice_we (word_we[0])
    );

    stream_reader #(.slice_t(word_t)) u_const_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (const_if),
        .beats    (desc_beats[constants]),
        .beat     (dma_rd_data),
        .mem_rdy  (1'b1),
        .slice    (const_word),
        .slice_we (word_we[1])
    );

    stream_reader #(.slice_t(block_t)) u_tri_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctl      (tri_if),
        .beats    (desc_beats[triangles]),
        .beat     (dma_rd_data),
        .mem_rdy  (mem_rdy),
        .slice    (block_data),
        .slice_we (block_we)
    );

    assign word_data     = ray_word | const_word;
    assign compute_start = load_done;

endmodule

`default_nettype wire

//--- logic/read_sequencer.sv
`default_nettype none

module read_sequencer (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      run_start,
    input  logic [2:0][loader_pkg::host_addr_w-1:0]   desc_addr,
    input  logic [2:0][loader_pkg::beat_cnt_w-1:0]    desc_beats,
    input  logic [2:0]                                desc_enable,
    input  logic                                      dma_empty,
    input  logic                                      dma_rd_done,
    dma_stream_if.sequencer                           ray_if,
    dma_stream_if.sequencer                           const_if,
    dma_stream_if.sequencer                           tri_if,
    output logic                                      dma_rd_go,
    output logic                                      dma_rd_en,
    output logic [loader_pkg::host_addr_w-1:0]        dma_rd_addr,
    output logic [loader_pkg::beat_cnt_w-1:0]         dma_rd_size,
    output logic                                      load_done
);
    import loader_pkg::*;

    stream_e    cur;
    logic       busy;
    logic       launched;
    logic       advance;
    logic       done_q;
    logic [2:0] sel;
    logic [2:0] start_vec;
    logic [2:0] go_vec;
    logic [2:0] pop_vec;
    logic [2:0] clr_vec;
    logic [2:0] fin_vec;

    assign go_vec  = {tri_if.go, const_if.go, ray_if.go};
    assign pop_vec = {tri_if.pop, const_if.pop, ray_if.pop};
    assign clr_vec = {tri_if.done_clr, const_if.done_clr, ray_if.done_clr};
    assign fin_vec = {tri_if.finished, const_if.finished, ray_if.finished};

    // Only the active reader reaches the DMA port
    assign sel       = busy ? (3'b001 << cur) : 3'b000;
    assign start_vec = (busy && desc_enable[cur] && !launched) ? sel : 3'b000;
    assign advance   = busy && (!desc_enable[cur] || fin_vec[cur]);
    assign dma_rd_go = |(go_vec & sel);
    assign dma_rd_en = |(pop_vec & sel);

    assign ray_if.start       = start_vec[ray_table];
    assign const_if.start     = start_vec[constants];
    assign tri_if.start       = start_vec[triangles];
    assign ray_if.empty       = dma_empty;
    assign const_if.empty     = dma_empty;
    assign tri_if.empty       = dma_empty;
    assign ray_if.beat_done   = done_q;
    assign const_if.beat_done = done_q;
    assign tri_if.beat_done   = done_q;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cur       <= ray_table;
            busy      <= 1'b0;
            launched  <= 1'b0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (!busy) begin
                if (run_start) begin
                    busy     <= 1'b1;
                    cur      <= ray_table;
                    launched <= 1'b0;
                end
            end else if (advance) begin
                launched <= 1'b0;
                if (cur == triangles) begin
                    busy      <= 1'b0;
                    load_done <= 1'b1;
                end else begin
                    cur <= stream_e'(cur + 2'd1);
                end
            end else if (|start_vec) begin
                launched <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|start_vec) begin
            dma_rd_addr <= desc_addr[cur];
            dma_rd_size <= desc_beats[cur];
        end
    end

    // DMA completion held until the reader has drained its last beat
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (|clr_vec) begin
            done_q <= 1'b0;
        end else if (dma_rd_done) begin
            done_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/stream_reader.sv
`default_nettype none

module stream_reader #(
    parameter type slice_t = loader_pkg::word_t
) (
    input  logic                                clk,
    input  logic                                rst_n,
    dma_stream_if.reader                        ctl,
    input  logic [loader_pkg::beat_cnt_w-1:0]   beats,
    input  loader_pkg::beat_t                   beat,
    input  logic                                mem_rdy,
    output slice_t                              slice,
    output logic                                slice_we
);
    import loader_pkg::*;

    localparam int slice_w  = $bits(slice_t);
    localparam int n_slices = beat_w / slice_w;
    localparam int idx_w    = $clog2(n_slices);

    typedef enum logic [2:0] {
        rd_idle,
        rd_go,
        rd_fetch,
        rd_unpack,
        rd_wait_done
    } rd_state_e;

    rd_state_e             state;
    logic [beat_cnt_w-1:0] beats_left;
    logic [idx_w-1:0]      slice_idx;
    logic                  last_slice;
    slice_t                shreg [n_slices];

    assign ctl.go       = (state == rd_go);
    assign ctl.pop      = (state == rd_fetch) && !ctl.empty;
    assign ctl.done_clr = (state == rd_wait_done) && ctl.beat_done;
    assign ctl.finished = (state == rd_wait_done) && ctl.beat_done;

    // Idle reader drives zero so the word outputs can be ORed
    assign slice_we   = (state == rd_unpack) && mem_rdy;
    assign slice      = (state == rd_unpack) ? shreg[0] : '0;
    assign last_slice = (slice_idx == idx_w'(n_slices - 1));

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= rd_idle;
            beats_left <= '0;
            slice_idx  <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (ctl.start) begin
                        state      <= rd_go;
                        beats_left <= beats;
                    end
                end
                rd_go: begin
                    state <= (beats_left == '0) ? rd_wait_done : rd_fetch;
                end
                rd_fetch: begin
                    if (ctl.pop) begin
                        state      <= rd_unpack;
                        beats_left <= beats_left - 1'b1;
                        slice_idx  <= '0;
                    end
                end
                rd_unpack: begin
                    if (slice_we) begin
                        slice_idx <= slice_idx + 1'b1;
                        if (last_slice) begin
                            state <= (beats_left == '0) ? rd_wait_done : rd_fetch;
                        end
                    end
                end
                rd_wait_done: begin
                    if (ctl.finished) begin
                        state <= rd_idle;
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

    // Lowest slice leaves first
    always_ff @(posedge clk) begin
        if (ctl.pop) begin
            for (int i = 0; i < n_slices; i++) begin
                shreg[i] <= beat[i*slice_w +: slice_w];
            end
        end else if (slice_we) begin
            for (int i = 0; i < n_slices - 1; i++) begin
                shreg[i] <= shreg[i+1];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mmio_config.sv
`default_nettype none

module mmio_config (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      mmio_wr_en,
    input  logic [loader_pkg::mmio_addr_w-1:0]        mmio_wr_addr,
    input  logic [loader_pkg::mmio_data_w-1:0]        mmio_wr_data,
    input  logic                                      load_done,
    output logic                                      run_start,
    output logic [2:0][loader_pkg::host_addr_w-1:0]   desc_addr,
    output logic [2:0][loader_pkg::beat_cnt_w-1:0]    desc_beats,
    output logic [2:0]                                desc_enable,
    output logic [loader_pkg::mmio_data_w-1:0]        mmio_rd_data
);
    import loader_pkg::*;

    // First three states line up with the stream order
    typedef enum logic [1:0] {
        cap_ray,
        cap_const,
        cap_tri,
        cap_run
    } cap_state_e;

    cap_state_e state;
    logic       desc_wr;
    logic       status_clr;
    logic [1:0] cap_idx;

    assign desc_wr    = mmio_wr_en && !mmio_wr_addr[mmio_sel_bit];
    assign status_clr = mmio_wr_en && mmio_wr_addr[mmio_sel_bit];
    assign cap_idx    = state;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state       <= cap_ray;
            run_start   <= 1'b0;
            desc_enable <= '0;
        end else begin
            run_start <= 1'b0;
            if (desc_wr) begin
                if (state == cap_run) begin
                    run_start <= 1'b1;
                    state     <= cap_ray;
                end else begin
                    desc_enable[cap_idx] <= mmio_wr_addr[mmio_req_bit];
                    state                <= cap_state_e'(state + 2'd1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_wr && state != cap_run) begin
            desc_addr[cap_idx]  <= mmio_wr_data;
            desc_beats[cap_idx] <= mmio_wr_addr[mmio_size_msb:mmio_size_lsb];
        end
    end

    // Host clear wins over a finishing load
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            mmio_rd_data <= status_idle;
        end else if (status_clr) begin
            mmio_rd_data <= status_idle;
        end else if (load_done) begin
            mmio_rd_data <= status_loaded;
        end
    end

endmodule

`default_nettype wire

//--- logic/dma_stream_if.sv
`default_nettype none

interface dma_stream_if;

    logic start;
    logic empty;
    logic beat_done;
    logic go;
    logic pop;
    logic done_clr;
    logic finished;

    modport reader (
        input  start, empty, beat_done,
        output go, pop, done_clr, finished
    );

    modport sequencer (
        output start, empty, beat_done,
        input  go, pop, done_clr, finished
    );

endinterface

`default_nettype wire

//--- logic/loader_pkg.sv
`default_nettype none

package loader_pkg;

    // Bus widths
    localparam int beat_w      = 512;
    localparam int host_addr_w = 64;
    localparam int beat_cnt_w  = 14;
    localparam int mmio_addr_w = 16;
    localparam int mmio_data_w = 64;

    // Slice and beat payloads
    typedef logic [31:0]       word_t;
    typedef logic [127:0]      block_t;
    typedef logic [beat_w-1:0] beat_t;

    // Load order of the input streams
    typedef enum logic [1:0] {
        ray_table,
        constants,
        triangles
    } stream_e;

    // MMIO write address fields
    localparam int mmio_sel_bit  = 0;
    localparam int mmio_req_bit  = 15;
    localparam int mmio_size_lsb = 1;
    localparam int mmio_size_msb = 14;

    // Host status word
    localparam logic [mmio_data_w-1:0] status_idle   = 64'd0;
    localparam logic [mmio_data_w-1:0] status_loaded = 64'd1;

endpackage

`default_nettype wire
